// ==== src/alu_pkg.sv ====
package alu_pkg;

   // Opcodes as written to REG_OP.
   typedef enum logic [2:0] {
      OP_ADD    = 3'd0,
      OP_SUB    = 3'd1,
      OP_CMP    = 3'd2,
      OP_AND    = 3'd3,
      OP_OR     = 3'd4,
      OP_XOR    = 3'd5,
      OP_PASS_M = 3'd6,
      OP_NOT_M  = 3'd7
   } alu_op_t;

   // 74181 function select, A is m and B is a.
   localparam logic [3:0] S_ADD    = 4'b1001;
   localparam logic [3:0] S_SUB    = 4'b0110;
   localparam logic [3:0] S_AND    = 4'b1011;
   localparam logic [3:0] S_OR     = 4'b1110;
   localparam logic [3:0] S_XOR    = 4'b0110;
   localparam logic [3:0] S_PASS_A = 4'b1111;
   localparam logic [3:0] S_NOT_A  = 4'b0000;

   // Register map.
   localparam logic [2:0] REG_A    = 3'd0;
   localparam logic [2:0] REG_M    = 3'd1;
   localparam logic [2:0] REG_OP   = 3'd2;
   localparam logic [2:0] REG_RES  = 3'd3;
   localparam logic [2:0] REG_STAT = 3'd4;

   typedef struct packed {
      logic [31:0] a;
      logic [31:0] m;
      alu_op_t     op;
   } alu_req_t;

   typedef struct packed {
      logic [32:0] alu;
      logic        aeqm;
   } alu_rsp_t;

   typedef struct packed {
      logic [3:0] aluf;
      logic       alumode;
      logic       cin0;
   } alu_ctl_t;

   // Group propagate and generate, active high.
   typedef struct packed {
      logic [7:0] x;
      logic [7:0] y;
   } grp_xy_t;

   // Bit k is the active low carry into bit 4k.
   typedef logic [8:1] carry_t;

   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [2:0]  adr;
      logic [31:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_rsp_t;

endpackage

// ==== src/ic_74s181.sv ====
`timescale 1ns/1ps

module ic_74s181 (
   input  logic [3:0] i_a,
   input  logic [3:0] i_b,
   input  logic [3:0] i_s,
   input  logic       i_m,
   input  logic       i_cin_n,
   output logic [3:0] o_f,
   output logic       o_x,
   output logic       o_y,
   output logic       o_cout_n,
   output logic       o_aeb
);

   logic [3:0] g;
   logic [3:0] p;
   logic [3:0] h;
   logic [3:0] c;
   logic       cin;

   // Per-bit generate, picked by S3 and S2.
   assign g = i_a & ((i_b & {4{i_s[3]}}) | (~i_b & {4{i_s[2]}}));

   // Per-bit propagate, picked by S1 and S0.
   assign p = i_a | (i_b & {4{i_s[0]}}) | (~i_b & {4{i_s[1]}});

   // Half sum; g always implies p.
   assign h = p ^ g;

   assign cin = ~i_cin_n;

   // Lookahead carries inside the slice.
   assign c[0] = cin;
   assign c[1] = g[0] | (p[0] & cin);
   assign c[2] = g[1]
                 | (p[1] & g[0])
                 | (p[1] & p[0] & cin);
   assign c[3] = g[2]
                 | (p[2] & g[1])
                 | (p[2] & p[1] & g[0])
                 | (p[2] & p[1] & p[0] & cin);

   // Logic mode forces every internal carry high.
   assign o_f = i_m ? ~h : (h ^ c);

   // Group terms for the 74182.
   assign o_x = &p;
   assign o_y = g[3]
                | (p[3] & g[2])
                | (p[3] & p[2] & g[1])
                | (p[3] & p[2] & p[1] & g[0]);

   assign o_cout_n = ~(o_y | (o_x & cin));

   // High only when F is all ones.
   assign o_aeb = &o_f;

endmodule

// ==== src/ic_74s182.sv ====
`timescale 1ns/1ps

module ic_74s182 (
   input  logic [3:0] i_x,
   input  logic [3:0] i_y,
   input  logic       i_cin_n,
   output logic       o_cnx_n,
   output logic       o_cny_n,
   output logic       o_cnz_n,
   output logic       o_x,
   output logic       o_y
);

   logic cin;

   assign cin = ~i_cin_n;

   // Carries into groups 1 to 3.
   assign o_cnx_n = ~(i_y[0] | (i_x[0] & cin));
   assign o_cny_n = ~(i_y[1]
                      | (i_x[1] & i_y[0])
                      | (i_x[1] & i_x[0] & cin));
   assign o_cnz_n = ~(i_y[2]
                      | (i_x[2] & i_y[1])
                      | (i_x[2] & i_x[1] & i_y[0])
                      | (i_x[2] & i_x[1] & i_x[0] & cin));

   // Block terms over all four groups.
   assign o_x = &i_x;
   assign o_y = i_y[3]
                | (i_x[3] & i_y[2])
                | (i_x[3] & i_x[2] & i_y[1])
                | (i_x[3] & i_x[2] & i_x[1] & i_y[0]);

endmodule

// ==== src/alu_carry_tree.sv ====
`timescale 1ns/1ps

module alu_carry_tree (
   input  alu_pkg::grp_xy_t i_xy,
   input  logic             i_cin0,
   output alu_pkg::carry_t  o_cin
);

   wire [8:1] cin_n;
   wire       cin16_n;
   wire       x_lo;
   wire       y_lo;
   wire       x_hi;
   wire       y_hi;

   // Low half covers groups 0 to 3.
   ic_74s182 u_lo (
      .i_x     (i_xy.x[3:0]),
      .i_y     (i_xy.y[3:0]),
      .i_cin_n (~i_cin0),
      .o_cnx_n (cin_n[1]),
      .o_cny_n (cin_n[2]),
      .o_cnz_n (cin_n[3]),
      .o_x     (x_lo),
      .o_y     (y_lo)
   );

   // Second level makes cin16_n and cin32_n.
   ic_74s182 u_top (
      .i_x     ({2'b00, x_hi, x_lo}),
      .i_y     ({2'b00, y_hi, y_lo}),
      .i_cin_n (~i_cin0),
      .o_cnx_n (cin16_n),
      .o_cny_n (cin_n[8]),
      .o_cnz_n (),
      .o_x     (),
      .o_y     ()
   );

   // High half covers groups 4 to 7.
   ic_74s182 u_hi (
      .i_x     (i_xy.x[7:4]),
      .i_y     (i_xy.y[7:4]),
      .i_cin_n (cin16_n),
      .o_cnx_n (cin_n[5]),
      .o_cny_n (cin_n[6]),
      .o_cnz_n (cin_n[7]),
      .o_x     (x_hi),
      .o_y     (y_hi)
   );

   assign cin_n[4] = cin16_n;
   assign o_cin    = cin_n;

endmodule

// ==== src/alu01.sv ====
`timescale 1ns/1ps

module alu01 (
   input  alu_pkg::alu_req_t i_req,
   input  alu_pkg::alu_ctl_t i_ctl,
   input  alu_pkg::carry_t   i_cin,
   output alu_pkg::grp_xy_t  o_xy,
   output alu_pkg::alu_rsp_t o_rsp
);

   wire [7:0]  slice_cin_n;
   wire [31:0] f_lo;
   wire [7:0]  grp_x;
   wire [7:0]  grp_y;
   wire [7:0]  aeqm_bits;
   wire [3:0]  sign_f;

   // Bottom slice takes the inverted carry-in.
   assign slice_cin_n = {i_cin[7:1], ~i_ctl.cin0};

   for (genvar i = 0; i < 8; i++) begin : g_slice
      ic_74s181 u_slice (
         .i_a      (i_req.m[4*i +: 4]),
         .i_b      (i_req.a[4*i +: 4]),
         .i_s      (i_ctl.aluf),
         .i_m      (i_ctl.alumode),
         .i_cin_n  (slice_cin_n[i]),
         .o_f      (f_lo[4*i +: 4]),
         .o_x      (grp_x[i]),
         .o_y      (grp_y[i]),
         .o_cout_n (),
         .o_aeb    (aeqm_bits[i])
      );
   end

   // Sign slice gives bit 32 of the extended operands.
   ic_74s181 u_sign (
      .i_a      ({3'b000, i_req.m[31]}),
      .i_b      ({3'b000, i_req.a[31]}),
      .i_s      (i_ctl.aluf),
      .i_m      (i_ctl.alumode),
      .i_cin_n  (i_cin[8]),
      .o_f      (sign_f),
      .o_x      (),
      .o_y      (),
      .o_cout_n (),
      .o_aeb    ()
   );

   assign o_xy = '{x: grp_x, y: grp_y};

   // Any slice pulling AEB low drops the shared line.
   assign o_rsp = '{alu: {sign_f[0], f_lo}, aeqm: &aeqm_bits};

endmodule

// ==== src/alu_ctl.sv ====
`timescale 1ns/1ps

module alu_ctl (
   input  alu_pkg::alu_op_t  i_op,
   output alu_pkg::alu_ctl_t o_ctl
);

   import alu_pkg::*;

   always_comb begin
      o_ctl = '{aluf: S_ADD, alumode: 1'b0, cin0: 1'b0};
      case (i_op)
         OP_ADD: begin
            o_ctl.aluf = S_ADD;
         end
         // m plus not a plus one.
         OP_SUB: begin
            o_ctl.aluf = S_SUB;
            o_ctl.cin0 = 1'b1;
         end
         // All ones when m equals a.
         OP_CMP: begin
            o_ctl.aluf = S_SUB;
         end
         OP_AND: begin
            o_ctl.aluf    = S_AND;
            o_ctl.alumode = 1'b1;
         end
         OP_OR: begin
            o_ctl.aluf    = S_OR;
            o_ctl.alumode = 1'b1;
         end
         OP_XOR: begin
            o_ctl.aluf    = S_XOR;
            o_ctl.alumode = 1'b1;
         end
         OP_PASS_M: begin
            o_ctl.aluf    = S_PASS_A;
            o_ctl.alumode = 1'b1;
         end
         OP_NOT_M: begin
            o_ctl.aluf    = S_NOT_A;
            o_ctl.alumode = 1'b1;
         end
         default: begin
            o_ctl.aluf = S_ADD;
         end
      endcase
   end

endmodule

// ==== src/alu_wb_regs.sv ====
`timescale 1ns/1ps

module alu_wb_regs (
   input  logic              i_clk,
   input  logic              i_arst_n,
   input  alu_pkg::wb_req_t  i_wb,
   output alu_pkg::wb_rsp_t  o_wb,
   output alu_pkg::alu_req_t o_req,
   input  alu_pkg::alu_rsp_t i_rsp
);

   import alu_pkg::*;

   logic [31:0] a_q;
   logic [31:0] m_q;
   alu_op_t     op_q;
   alu_rsp_t    res_q;
   logic        ack_q;
   logic [31:0] dat_q;
   logic [31:0] rd_data;
   logic        take;

   // A request is taken once, never while its ack is up.
   assign take = i_wb.cyc & i_wb.stb & ~ack_q;

   always_comb begin
      case (i_wb.adr)
         REG_A:    rd_data = a_q;
         REG_M:    rd_data = m_q;
         REG_OP:   rd_data = {29'd0, op_q};
         REG_RES:  rd_data = res_q.alu[31:0];
         REG_STAT: rd_data = {30'd0, res_q.aeqm, res_q.alu[32]};
         default:  rd_data = '0;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         a_q   <= '0;
         m_q   <= '0;
         op_q  <= OP_ADD;
         res_q <= '0;
         ack_q <= 1'b0;
      end else begin
         ack_q <= take;
         // Result follows the operands one clock later.
         res_q <= i_rsp;
         if (take && i_wb.we) begin
            case (i_wb.adr)
               REG_A:   a_q  <= i_wb.dat;
               REG_M:   m_q  <= i_wb.dat;
               REG_OP:  op_q <= alu_op_t'(i_wb.dat[2:0]);
               default: ;
            endcase
         end
      end
   end

   // Read data lines up with ack.
   always_ff @(posedge i_clk) begin
      if (take && !i_wb.we) begin
         dat_q <= rd_data;
      end
   end

   assign o_wb  = '{ack: ack_q, dat: dat_q};
   assign o_req = '{a: a_q, m: m_q, op: op_q};

endmodule

// ==== src/alu_top.sv ====
`timescale 1ns/1ps

module alu_top (
   input  logic             i_clk,
   input  logic             i_arst_n,
   input  alu_pkg::wb_req_t i_wb,
   output alu_pkg::wb_rsp_t o_wb
);

   import alu_pkg::*;

   alu_req_t req;
   alu_rsp_t rsp;
   alu_ctl_t ctl;
   grp_xy_t  xy;
   carry_t   cin;

   alu_wb_regs u_regs (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_wb     (i_wb),
      .o_wb     (o_wb),
      .o_req    (req),
      .i_rsp    (rsp)
   );

   alu_ctl u_ctl (
      .i_op  (req.op),
      .o_ctl (ctl)
   );

   alu01 u_alu (
      .i_req (req),
      .i_ctl (ctl),
      .i_cin (cin),
      .o_xy  (xy),
      .o_rsp (rsp)
   );

   // Group terms do not depend on carries, so no loop.
   alu_carry_tree u_carry (
      .i_xy   (xy),
      .i_cin0 (ctl.cin0),
      .o_cin  (cin)
   );

endmodule

// ==== bench/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
   output logic o_clk
);

   // Half of the 40 ns period.
   localparam int HALF_NS = 20;

   initial begin
      o_clk = 1'b0;
      forever #(HALF_NS) o_clk = ~o_clk;
   end

endmodule

// ==== bench/tb_alu_top.sv ====
`timescale 1ns/1ps

module tb_alu_top;

   import alu_pkg::*;

   localparam int CLK_NS        = 40;
   localparam int RESET_CYC     = 10;
   localparam int N_EDGE        = 6;
   localparam int N_RAND        = 16;
   localparam int N_OPS         = 2 * N_EDGE + 9 * N_RAND;
   localparam int TRANS_PER_OP  = 5;
   localparam int N_TRANS       = 5 + 3 + N_OPS * TRANS_PER_OP;
   localparam int CYC_PER_TRANS = 4;
   localparam int WDOG_NS       = (RESET_CYC + N_TRANS * CYC_PER_TRANS + 100) * CLK_NS;

   // One ALU run as seen over the bus.
   typedef struct packed {
      logic [31:0] a;
      logic [31:0] m;
      alu_op_t     op;
      logic [31:0] res;
      logic [31:0] stat;
   } obs_t;

   logic    clk;
   logic    arst_n;
   wb_req_t wb_req;
   wb_rsp_t wb_rsp;

   obs_t    obs_q[$];
   event    obs_ev;
   int      n_obs;
   int      n_checked;
   integer  seed;

   tb_clkgen u_clkgen (
      .o_clk (clk)
   );

   alu_top u_dut (
      .i_clk    (clk),
      .i_arst_n (arst_n),
      .i_wb     (wb_req),
      .o_wb     (wb_rsp)
   );

   task automatic check_val(input string name, input logic [32:0] got,
                            input logic [32:0] want);
      if (got !== want) begin
         $display("[FAIL] %0d ns %s: got 0x%0h, expected 0x%0h", $time, name, got, want);
         $display("TB FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // 33-bit result on sign-extended operands, aeqm on the low 32 bits.
   function automatic alu_rsp_t alu_model(input logic [31:0] a, input logic [31:0] m,
                                          input alu_op_t op);
      logic [32:0] ae;
      logic [32:0] me;
      logic [32:0] r;
      alu_rsp_t    rsp;
      ae = {a[31], a};
      me = {m[31], m};
      case (op)
         OP_ADD:    r = me + ae;
         OP_SUB:    r = me - ae;
         OP_CMP:    r = me - ae - 33'd1;
         OP_AND:    r = me & ae;
         OP_OR:     r = me | ae;
         OP_XOR:    r = me ^ ae;
         OP_PASS_M: r = me;
         OP_NOT_M:  r = ~me;
         default:   r = '0;
      endcase
      rsp.alu  = r;
      rsp.aeqm = &r[31:0];
      return rsp;
   endfunction

   // Drive on the falling edge, wait for ack and check its shape.
   task automatic bus_cycle(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
      int lat;
      @(negedge clk);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = wdat;
      lat = 0;
      do begin
         @(negedge clk);
         lat++;
      end while (!wb_rsp.ack);
      rdat   = wb_rsp.dat;
      wb_req = '0;
      check_val("ack latency", 33'(lat), 33'd1);
      @(negedge clk);
      check_val("ack", {32'd0, wb_rsp.ack}, 33'd0);
   endtask

   task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
      logic [31:0] unused;
      bus_cycle(1'b1, adr, dat, unused);
   endtask

   task automatic wb_read(input logic [2:0] adr, output logic [31:0] dat);
      bus_cycle(1'b0, adr, 32'd0, dat);
   endtask

   task automatic run_op(input alu_op_t op, input logic [31:0] m, input logic [31:0] a);
      obs_t ob;
      wb_write(REG_A, a);
      wb_write(REG_M, m);
      wb_write(REG_OP, {29'd0, op});
      ob.a  = a;
      ob.m  = m;
      ob.op = op;
      wb_read(REG_RES, ob.res);
      wb_read(REG_STAT, ob.stat);
      obs_q.push_back(ob);
      n_obs++;
      ->obs_ev;
   endtask

   task automatic arith_pair(input logic [31:0] m, input logic [31:0] a);
      run_op(OP_ADD, m, a);
      run_op(OP_SUB, m, a);
   endtask

   initial begin : compare_results
      obs_t     ob;
      alu_rsp_t want;
      forever begin
         @(obs_ev);
         while (obs_q.size() > 0) begin
            ob   = obs_q.pop_front();
            want = alu_model(ob.a, ob.m, ob.op);
            check_val($sformatf("REG_RES op=%0d", ob.op), {1'b0, ob.res},
                      {1'b0, want.alu[31:0]});
            check_val($sformatf("REG_STAT op=%0d", ob.op), {1'b0, ob.stat},
                      {31'd0, want.aeqm, want.alu[32]});
            n_checked++;
         end
      end
   end

   initial begin : watchdog
      #(WDOG_NS);
      $display("Watchdog expired after %0d ns, the bus stopped answering", WDOG_NS);
      $display("TB FAILED");
      $fatal(1, "timeout");
   end

   initial begin : stimulus
      logic [31:0] m;
      logic [31:0] a;
      logic [31:0] rnd;
      logic [31:0] rd;
      arst_n    = 1'b0;
      wb_req    = '0;
      n_obs     = 0;
      n_checked = 0;
      seed      = 32'hf52ec791;
      repeat (RESET_CYC) @(negedge clk);
      arst_n = 1'b1;

      // Everything reads zero out of reset.
      for (int r = 0; r < 5; r++) begin
         wb_read(3'(r), rd);
         check_val($sformatf("reset reg %0d", r), {1'b0, rd}, 33'd0);
      end

      // Carries through every group in both directions.
      arith_pair(32'hffffffff, 32'h00000001);
      arith_pair(32'h7fffffff, 32'h00000001);
      arith_pair(32'h80000000, 32'h00000001);
      arith_pair(32'h00000000, 32'h00000001);
      arith_pair(32'hffffffff, 32'hffffffff);
      arith_pair(32'h0fffffff, 32'hf0000001);
      for (int k = 0; k < N_RAND; k++) begin
         m = $random(seed);
         a = $random(seed);
         arith_pair(m, a);
      end

      for (int k = 0; k < N_RAND; k++) begin
         m = $random(seed);
         a = $random(seed);
         run_op(OP_AND, m, a);
         run_op(OP_OR, m, a);
         run_op(OP_XOR, m, a);
         run_op(OP_PASS_M, m, a);
         run_op(OP_NOT_M, m, a);
      end

      // Equal operands, then one bit apart.
      for (int k = 0; k < N_RAND; k++) begin
         m   = $random(seed);
         rnd = $random(seed);
         run_op(OP_CMP, m, m);
         a = m ^ (32'd1 << rnd[4:0]);
         run_op(OP_CMP, m, a);
      end

      // Unused addresses still ack, with zero data.
      for (int r = 5; r < 8; r++) begin
         wb_read(3'(r), rd);
         check_val($sformatf("unused reg %0d", r), {1'b0, rd}, 33'd0);
      end

      @(negedge clk);
      if (n_checked != n_obs) begin
         $display("Only %0d of %0d results were compared", n_checked, n_obs);
         $display("TB FAILED");
         $fatal(1, "results left unchecked");
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

endmodule

// ==== vlog.f ====
src/alu_pkg.sv
src/ic_74s181.sv
src/ic_74s182.sv
src/alu_carry_tree.sv
src/alu01.sv
src/alu_ctl.sv
src/alu_wb_regs.sv
src/alu_top.sv
bench/tb_clkgen.sv
bench/tb_alu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_alu_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
